/* vlog.f */
cpuPkg.sv
fetchUnit.sv
controlUnit.sv
regFile.sv
alu.sv
dataMem.sv
multicycleCore.sv
multicycleCore_assertions.sv
tb_multicycleCore.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_multicycleCore -f vlog.f -o tbSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tbSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "All tests passed" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

/* tb_multicycleCore.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_multicycleCore;
    import cpuPkg::*;

    localparam int numTests = 8;
    localparam int watchdogNs = (numTests + 1) * 60 * 4 * 10 + 2000;

    logic     clk = 1'b0;
    logic     rst, run, loadEn;
    memAddr_t loadAddr;
    word_t    loadData;
    logic     retire, regWrite, memWrite;
    word_t    retirePc, wbData, memWrData;
    regAddr_t wbAddr;
    memAddr_t memAddr;

    int    seed = 10;
    int    cycle = 0;
    int    errorCount = 0;
    int    checkCount = 0;
    logic  idleCheck = 1'b0;              // Set while the core must stay parked
    word_t prog [256];
    int    progLen;
    word_t mReg [32];                     // Reference model state
    word_t mMem [256];
    word_t mPc;

    multicycleCore multicycleCore_i (
        .clk(clk), .rst(rst), .run(run), .loadEn(loadEn), .loadAddr(loadAddr),
        .loadData(loadData), .retire(retire), .regWrite(regWrite), .memWrite(memWrite),
        .retirePc(retirePc), .wbData(wbData), .memWrData(memWrData), .wbAddr(wbAddr),
        .memAddr(memAddr)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    always @(negedge clk) begin
        if (idleCheck && retire) begin
            $display("ERR %0t: retire pulse while run is low", $time);
            errorCount++;
        end
    end

    function automatic int randBelow(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic word_t encR(logic [6:0] f7, regAddr_t rs2, regAddr_t rs1,
                                   logic [2:0] f3, regAddr_t rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic word_t encI(logic [11:0] imm, regAddr_t rs1, logic [2:0] f3,
                                   regAddr_t rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t encS(logic [11:0] imm, regAddr_t rs2, regAddr_t rs1);
        return {imm[11:5], rs2, rs1, 3'd2, imm[4:0], OP_STORE};
    endfunction

    function automatic word_t encJ(logic [20:0] imm, regAddr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    // RV32I arithmetic by funct3 with alt selecting SUB or SRA
    function automatic word_t arith(logic [2:0] f3, logic alt, word_t a, word_t b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << sh;
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return (a >> sh) | ((alt && a[31]) ? ~(32'hFFFF_FFFF >> sh) : 32'h0);
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic reportMismatch(string what, word_t got, word_t exp);
        $display("ERR %0t: %s is %h, expected %h at pc %h", $time, what, got, exp, mPc);
        errorCount++;
    endtask

    // Clears data words 0 to 15 so later loads read known values
    task automatic buildInitProgram();
        for (int w = 0; w < 16; w++) begin
            prog[w] = encS({6'b0, w[3:0], 2'b00}, 5'd0, 5'd0);
        end
        prog[16] = encJ(21'd0, 5'd0);
        progLen = 16;
    endtask

    task automatic buildRandomProgram();
        int       kind, lim;
        regAddr_t rd, rs1, rs2;
        logic [2:0] f3;
        logic [6:0] f7;
        word_t    raw;
        for (int i = 0; i < 40; i++) begin
            kind = randBelow(16);
            rd   = regAddr_t'(randBelow(32));
            rs1  = regAddr_t'(randBelow(32));
            rs2  = regAddr_t'(randBelow(32));
            f3   = 3'(randBelow(8));
            raw  = $random(seed);
            f7   = ((f3 == 3'd0 || f3 == 3'd5) && raw[0]) ? 7'h20 : 7'h00;
            lim  = (40 - i < 6) ? 40 - i : 6;
            if (kind < 5) begin
                prog[i] = encR(f7, rs2, rs1, f3, rd);
            end else if (kind < 9 || kind == 15) begin
                if (f3 == 3'd1 || f3 == 3'd5) begin    // Shift amount sits in the rs2 field
                    prog[i] = encI({(f3 == 3'd5) ? f7 : 7'h00, rs2}, rs1, f3, rd, OP_IMM);
                end else begin
                    prog[i] = encI(raw[31:20], rs1, f3, rd, OP_IMM);
                end
            end else if (kind < 11) begin
                prog[i] = encI({6'b0, raw[5:2], 2'b00}, 5'd0, 3'd2, rd, OP_LOAD);
            end else if (kind < 13) begin
                prog[i] = encS({6'b0, raw[5:2], 2'b00}, rs2, 5'd0);
            end else if (kind == 13) begin
                prog[i] = encJ(21'((1 + randBelow(lim)) * 4), rd);   // Forward only
            end else if (raw[2:1] == 2'd0) begin
                prog[i] = encR(7'h01, rs2, rs1, f3, rd);
            end else if (raw[2:1] == 2'd1) begin
                prog[i] = encI({7'h10, rs2}, rs1, raw[3] ? 3'd1 : 3'd5, rd, OP_IMM);
            end else begin
                prog[i] = {raw[31:7], raw[3] ? 7'b0110111 : 7'b1100011};
            end
        end
        prog[40] = encJ(21'd0, 5'd0);
        progLen = 40;
    endtask

    // Steps the model by one instruction and compares the retirement trace
    task automatic checkRetire();
        word_t      inst, a, b, immI, immS, res, nextPc, addr;
        logic [2:0] f3;
        logic [6:0] f7;
        regAddr_t   rd;
        logic       writes, stores;
        inst   = prog[mPc[9:2]];
        f3     = inst[14:12];
        f7     = inst[31:25];
        rd     = inst[11:7];
        a      = mReg[inst[19:15]];
        b      = mReg[inst[24:20]];
        immI   = {{20{inst[31]}}, inst[31:20]};
        immS   = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        writes = 1'b0;
        stores = 1'b0;
        res    = '0;
        addr   = '0;
        nextPc = mPc + 32'd4;
        checkCount++;
        if (retirePc !== mPc) begin
            reportMismatch("retirePc", retirePc, mPc);
        end
        case (inst[6:0])
            OP_REG: begin
                writes = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
                res    = arith(f3, f7 == 7'h20, a, b);
            end
            OP_IMM: begin
                writes = (f3 == 3'd1) ? (f7 == 7'h00) :
                         (f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
                res    = arith(f3, f3 == 3'd5 && f7 == 7'h20, a, immI);
            end
            OP_LOAD: begin
                writes = (f3 == 3'd2);
                addr   = a + immI;
                res    = mMem[addr[9:2]];
            end
            OP_STORE: begin
                stores = (f3 == 3'd2);
                addr   = a + immS;
            end
            OP_JAL: begin
                writes = 1'b1;
                res    = mPc + 32'd4;
                nextPc = mPc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                                inst[30:21], 1'b0};
            end
            default: ;                    // Unsupported opcode moves only the PC
        endcase
        writes = writes && (rd != 5'd0);
        if (regWrite !== writes) begin
            reportMismatch("regWrite", {31'b0, regWrite}, {31'b0, writes});
        end else if (writes) begin
            if (wbAddr !== rd) begin
                reportMismatch("wbAddr", {27'b0, wbAddr}, {27'b0, rd});
            end
            if (wbData !== res) begin
                reportMismatch("wbData", wbData, res);
            end
        end
        if (memWrite !== stores) begin
            reportMismatch("memWrite", {31'b0, memWrite}, {31'b0, stores});
        end else if (stores) begin
            if (memAddr !== addr[9:2]) begin
                reportMismatch("memAddr", {24'b0, memAddr}, {24'b0, addr[9:2]});
            end
            if (memWrData !== b) begin
                reportMismatch("memWrData", memWrData, b);
            end
        end
        if (writes) begin
            mReg[rd] = res;
        end
        if (stores) begin
            mMem[addr[9:2]] = b;
        end
        mPc = nextPc;
    endtask

    task automatic runProgram(int testNum);
        int    errorsBefore, retired, selfHits, lastCycle, runCycle;
        word_t endPc;
        errorsBefore = errorCount;
        retired      = 0;
        selfHits     = 0;
        lastCycle    = 0;
        endPc        = word_t'(progLen * 4);
        @(posedge clk);
        #1;
        rst = 1'b1;
        run = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int r = 0; r < 32; r++) begin
            mReg[r] = '0;
        end
        mPc = '0;
        idleCheck = 1'b1;
        for (int i = 0; i <= progLen; i++) begin
            @(posedge clk);
            #1;
            loadEn   = 1'b1;
            loadAddr = memAddr_t'(i);
            loadData = prog[i];
        end
        @(posedge clk);
        #1;
        loadEn = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        idleCheck = 1'b0;
        run       = 1'b1;
        runCycle  = cycle;
        while (selfHits < 2) begin        // Second pass through the closing JAL
            @(negedge clk);
            if (retire) begin
                if (retired == 0 && cycle != runCycle + 3) begin
                    $display("ERR %0t: first retire in cycle %0d, expected %0d",
                             $time, cycle, runCycle + 3);
                    errorCount++;
                end else if (retired != 0 && cycle != lastCycle + 4) begin
                    $display("ERR %0t: retire spacing %0d cycles", $time, cycle - lastCycle);
                    errorCount++;
                end
                if (mPc == endPc) begin
                    selfHits++;
                end
                lastCycle = cycle;
                retired++;
                checkRetire();
            end
        end
        @(posedge clk);
        #1;
        run = 1'b0;
        $display("Test %0d done: %0d instructions retired, %0d errors",
                 testNum, retired, errorCount - errorsBefore);
    endtask

    initial begin
        rst      = 1'b1;
        run      = 1'b0;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        buildInitProgram();
        runProgram(0);
        for (int t = 1; t <= numTests; t++) begin
            buildRandomProgram();
            runProgram(t);
        end
        $display("Summary: %0d tests, %0d retirements checked, %0d errors",
                 numTests + 1, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        #(watchdogNs);
        $display("Watchdog expired at %0t, the programs did not complete", $time);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* multicycleCore_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module multicycleCore_assertions (
    input logic               clk,
    input logic               rst,
    input logic               run,
    input cpuPkg::ctrlState_t state,
    input logic               regWrite,
    input logic               memWrite,
    input logic               retire
);
    import cpuPkg::*;

    // Next state follows from the values at the launching edge
    assert property (@(posedge clk) !rst && state == STATE_IF && run |=> state == STATE_ID)
        else $error("IF did not advance to ID with run high");
    assert property (@(posedge clk) !rst && state == STATE_IF && !run |=> state == STATE_IF)
        else $error("IF left while run was low");
    assert property (@(posedge clk) !rst && state == STATE_ID |=> state == STATE_EX)
        else $error("ID not followed by EX");
    assert property (@(posedge clk) !rst && state == STATE_EX |=> state == STATE_WB)
        else $error("EX not followed by WB");
    assert property (@(posedge clk) !rst && state == STATE_WB |=> state == STATE_IF)
        else $error("WB not followed by IF");
    assert property (@(posedge clk) !rst && (regWrite || memWrite) |-> state == STATE_WB)
        else $error("Write strobe outside WB");
    assert property (@(posedge clk) !rst |-> retire == (state == STATE_WB))
        else $error("retire does not match the WB visit");

endmodule

bind controlUnit multicycleCore_assertions multicycleCore_assertions_i (
    .clk(clk), .rst(rst), .run(run), .state(state),
    .regWrite(regWrite), .memWrite(memWrite), .retire(retire)
);

`default_nettype wire

/* multicycleCore.sv */
`timescale 1ns/1ps
`default_nettype none

module multicycleCore (
    input  logic             clk,
    input  logic             rst,
    input  logic             run,
    input  logic             loadEn,
    input  cpuPkg::memAddr_t loadAddr,
    input  cpuPkg::word_t    loadData,
    output logic             retire,
    output logic             regWrite,
    output logic             memWrite,
    output cpuPkg::word_t    retirePc,
    output cpuPkg::word_t    wbData,
    output cpuPkg::word_t    memWrData,
    output cpuPkg::regAddr_t wbAddr,
    output cpuPkg::memAddr_t memAddr
);
    import cpuPkg::*;

    word_t    pc, instr, ir, nextPc;
    word_t    rd1, rd2, imm, aluA, aluB, aluResult, memRdata;
    logic     aSel, pcWrite, jump, wbFromMem;
    bSel_t    bSel;
    immKind_t immKind;
    aluOp_t   aluOp;

    fetchUnit fetchUnit_i (
        .clk(clk), .rst(rst), .pcWrite(pcWrite), .nextPc(nextPc),
        .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
        .pc(pc), .instr(instr)
    );

    controlUnit controlUnit_i (
        .clk(clk), .rst(rst), .run(run), .instr(instr), .ir(ir),
        .aSel(aSel), .bSel(bSel), .immKind(immKind), .aluOp(aluOp),
        .regWrite(regWrite), .memWrite(memWrite), .pcWrite(pcWrite),
        .jump(jump), .wbFromMem(wbFromMem), .retire(retire)
    );

    regFile regFile_i (
        .clk(clk), .rst(rst), .rs1(ir[19:15]), .rs2(ir[24:20]), .rd(wbAddr),
        .we(regWrite), .wd(wbData), .rd1(rd1), .rd2(rd2)
    );

    alu alu_i (.op(aluOp), .a(aluA), .b(aluB), .y(aluResult));

    dataMem dataMem_i (
        .clk(clk), .addr(memAddr), .we(memWrite), .wd(memWrData), .rdata(memRdata)
    );

    // Immediate extraction
    always_comb begin
        case (immKind)
            IMM_S:   imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
            IMM_J:   imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
            default: imm = {{20{ir[31]}}, ir[31:20]};
        endcase
    end

    assign aluA = aSel ? rd1 : pc;
    assign aluB = (bSel == B_IMM)  ? imm :
                  (bSel == B_FOUR) ? word_t'(4) : rd2;

    assign nextPc    = jump ? pc + imm : pc + word_t'(4);
    assign wbData    = wbFromMem ? memRdata : aluResult;  // JAL link comes from the ALU
    assign wbAddr    = ir[11:7];
    assign memAddr   = aluResult[9:2];
    assign memWrData = rd2;
    assign retirePc  = pc;                                // pc moves only after WB

endmodule

`default_nettype wire

/* dataMem.sv */
`timescale 1ns/1ps
`default_nettype none

module dataMem (
    input  logic             clk,
    input  cpuPkg::memAddr_t addr,
    input  logic             we,
    input  cpuPkg::word_t    wd,
    output cpuPkg::word_t    rdata
);
    import cpuPkg::*;

    word_t mem [DMEM_WORDS];

    // Read issued in EX lands in WB
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wd;
        end
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

/* alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  cpuPkg::aluOp_t op,
    input  cpuPkg::word_t  a,
    input  cpuPkg::word_t  b,
    output cpuPkg::word_t  y
);
    import cpuPkg::*;

    logic [4:0] shamt;
    logic       ltSigned;
    logic       ltUnsigned;

    assign shamt      = b[4:0];
    assign ltSigned   = $signed(a) < $signed(b);
    assign ltUnsigned = a < b;

    always_comb begin
        case (op)
            ALU_ADD:  y = a + b;
            ALU_SUB:  y = a - b;
            ALU_AND:  y = a & b;
            ALU_OR:   y = a | b;
            ALU_XOR:  y = a ^ b;
            ALU_SLL:  y = a << shamt;
            ALU_SRL:  y = a >> shamt;
            ALU_SRA:  y = word_t'($signed(a) >>> shamt);  // Sign fill
            ALU_SLT:  y = {{(XLEN-1){1'b0}}, ltSigned};
            ALU_SLTU: y = {{(XLEN-1){1'b0}}, ltUnsigned};
            default:  y = '0;                             // Unknown code
        endcase
    end

endmodule

`default_nettype wire

/* regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic             clk,
    input  logic             rst,
    input  cpuPkg::regAddr_t rs1,
    input  cpuPkg::regAddr_t rs2,
    input  cpuPkg::regAddr_t rd,
    input  logic             we,
    input  cpuPkg::word_t    wd,
    output cpuPkg::word_t    rd1,
    output cpuPkg::word_t    rd2
);
    import cpuPkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wd;
        end
    end

    // x0 is hardwired
    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* controlUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
    input  logic              clk,
    input  logic              rst,
    input  logic              run,
    input  cpuPkg::word_t     instr,
    output cpuPkg::word_t     ir,
    output logic              aSel,
    output cpuPkg::bSel_t     bSel,
    output cpuPkg::immKind_t  immKind,
    output cpuPkg::aluOp_t    aluOp,
    output logic              regWrite,
    output logic              memWrite,
    output logic              pcWrite,
    output logic              jump,
    output logic              wbFromMem,
    output logic              retire
);
    import cpuPkg::*;

    ctrlState_t state;
    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    regAddr_t   rdField;
    logic       legal;
    logic       wbEn;                     // Instruction writes rd
    logic       stEn;                     // Instruction writes data memory
    logic       inWb;

    assign opcode  = ir[6:0];
    assign funct3  = ir[14:12];
    assign funct7  = ir[31:25];
    assign rdField = ir[11:7];

    // Sequencer, parks in IF while run is low
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= STATE_IF;
        end else begin
            case (state)
                STATE_IF: state <= run ? STATE_ID : STATE_IF;
                STATE_ID: state <= STATE_EX;
                STATE_EX: state <= STATE_WB;
                default:  state <= STATE_IF;
            endcase
        end
    end

    // Instruction register
    always_ff @(posedge clk) begin
        if (rst) begin
            ir <= '0;
        end else if (state == STATE_IF && run) begin
            ir <= instr;
        end
    end

    // Decoder, anything not matched retires as a no-op
    always_comb begin
        aSel      = 1'b1;                 // rs1
        bSel      = B_REG;
        immKind   = IMM_I;
        aluOp     = ALU_ADD;
        legal     = 1'b1;
        wbEn      = 1'b0;
        stEn      = 1'b0;
        jump      = 1'b0;
        wbFromMem = 1'b0;
        case (opcode)
            OP_REG: begin
                case ({funct7, funct3})
                    {F7_BASE, 3'b000}: aluOp = ALU_ADD;
                    {F7_ALT,  3'b000}: aluOp = ALU_SUB;
                    {F7_BASE, 3'b111}: aluOp = ALU_AND;
                    {F7_BASE, 3'b110}: aluOp = ALU_OR;
                    {F7_BASE, 3'b100}: aluOp = ALU_XOR;
                    {F7_BASE, 3'b010}: aluOp = ALU_SLT;
                    {F7_BASE, 3'b011}: aluOp = ALU_SLTU;
                    {F7_BASE, 3'b001}: aluOp = ALU_SLL;
                    {F7_BASE, 3'b101}: aluOp = ALU_SRL;
                    {F7_ALT,  3'b101}: aluOp = ALU_SRA;
                    default:           legal = 1'b0;
                endcase
                wbEn = legal;
            end
            OP_IMM: begin
                bSel = B_IMM;
                case (funct3)
                    3'b000: aluOp = ALU_ADD;
                    3'b111: aluOp = ALU_AND;
                    3'b110: aluOp = ALU_OR;
                    3'b100: aluOp = ALU_XOR;
                    3'b010: aluOp = ALU_SLT;
                    3'b011: aluOp = ALU_SLTU;
                    3'b001: begin
                        aluOp = ALU_SLL;
                        legal = (funct7 == F7_BASE);
                    end
                    default: begin            // 101 is SRLI or SRAI
                        aluOp = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                        legal = (funct7 == F7_BASE) || (funct7 == F7_ALT);
                    end
                endcase
                wbEn = legal;
            end
            OP_LOAD: begin
                bSel      = B_IMM;
                wbEn      = (funct3 == F3_WORD);
                wbFromMem = 1'b1;
            end
            OP_STORE: begin
                bSel    = B_IMM;
                immKind = IMM_S;
                stEn    = (funct3 == F3_WORD);
            end
            OP_JAL: begin
                aSel    = 1'b0;               // ALU forms pc + 4 for the link
                bSel    = B_FOUR;
                immKind = IMM_J;
                wbEn    = 1'b1;
                jump    = 1'b1;
            end
            default: legal = 1'b0;
        endcase
    end

    // Strobes only in WB
    assign inWb     = (state == STATE_WB);
    assign regWrite = inWb && wbEn && (rdField != '0);  // x0 writes dropped here
    assign memWrite = inWb && stEn;
    assign pcWrite  = inWb;
    assign retire   = inWb;

endmodule

`default_nettype wire

/* fetchUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchUnit (
    input  logic             clk,
    input  logic             rst,
    input  logic             pcWrite,
    input  cpuPkg::word_t    nextPc,
    input  logic             loadEn,
    input  cpuPkg::memAddr_t loadAddr,
    input  cpuPkg::word_t    loadData,
    output cpuPkg::word_t    pc,
    output cpuPkg::word_t    instr
);
    import cpuPkg::*;

    word_t    imem [IMEM_WORDS];  // Instruction store
    memAddr_t fetchIdx;

    // Byte address to word index, wraps at 256 words
    assign fetchIdx = pc[9:2];

    // Program counter
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (pcWrite) begin
            pc <= nextPc;                 // Only at the end of WB
        end
    end

    // Testbench load port
    always_ff @(posedge clk) begin
        if (loadEn) begin
            imem[loadAddr] <= loadData;
        end
    end

    // Asynchronous read so IF sees the word in the same cycle
    assign instr = imem[fetchIdx];

endmodule

`default_nettype wire

/* cpuPkg.sv */
`default_nettype none

package cpuPkg;

    localparam int XLEN = 32;                 // Data and address width
    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 256;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0] regAddr_t;
    typedef logic [7:0] memAddr_t;            // Word index into either memory
    typedef logic [3:0] aluOp_t;
    typedef logic [6:0] opcode_t;
    typedef logic [1:0] bSel_t;
    typedef logic [1:0] immKind_t;

    // ALU operation codes
    localparam aluOp_t ALU_ADD  = 4'b0000;
    localparam aluOp_t ALU_SUB  = 4'b0001;
    localparam aluOp_t ALU_AND  = 4'b0010;
    localparam aluOp_t ALU_OR   = 4'b0011;
    localparam aluOp_t ALU_SLL  = 4'b0100;
    localparam aluOp_t ALU_SRL  = 4'b0101;
    localparam aluOp_t ALU_SRA  = 4'b0110;
    localparam aluOp_t ALU_SLT  = 4'b0111;
    localparam aluOp_t ALU_SLTU = 4'b1001;
    localparam aluOp_t ALU_XOR  = 4'b1101;

    // Major opcodes of the supported subset
    localparam opcode_t OP_REG   = 7'b0110011;
    localparam opcode_t OP_IMM   = 7'b0010011;
    localparam opcode_t OP_LOAD  = 7'b0000011;
    localparam opcode_t OP_STORE = 7'b0100011;
    localparam opcode_t OP_JAL   = 7'b1101111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // SUB and arithmetic shifts
    localparam logic [2:0] F3_WORD = 3'b010;      // Only word accesses

    // Second ALU operand
    localparam bSel_t B_REG  = 2'b00;
    localparam bSel_t B_IMM  = 2'b01;
    localparam bSel_t B_FOUR = 2'b10;

    // Immediate formats
    localparam immKind_t IMM_I = 2'b00;
    localparam immKind_t IMM_S = 2'b01;
    localparam immKind_t IMM_J = 2'b10;

    typedef enum logic [1:0] {
        STATE_IF,
        STATE_ID,
        STATE_EX,
        STATE_WB
    } ctrlState_t;

endpackage

`default_nettype wire
